// File: source/fetch_pkg.sv
package fetch_pkg;

  // machine word, also the fetch address width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;   // instruction address
  typedef logic [XLEN-1:0] inst_t;   // raw instruction word

  // 2-bit saturating direction counter
  // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
  typedef logic [1:0] ctr_t;

  localparam ctr_t CTR_RESET = 2'b01;  // weakly not taken

  // instruction trap flags, one bit per cause
  typedef logic [1:0] trap_t;

  localparam int TRAP_MISALIGNED   = 0;  // pc not word aligned
  localparam int TRAP_ACCESS_FAULT = 1;  // slave answered pslverr

  // byte step between two sequential instructions
  localparam addr_t INST_BYTES = 32'd4;

endpackage

// File: source/fetch_req_if.sv
`timescale 1ns/100ps

// one fetch request, pc stage -> fetch stage
// moves on a clock edge with valid and ready both high
interface fetch_req_if;

  import fetch_pkg::*;

  logic  valid;        // request present
  logic  ready;        // fetch stage can take it
  addr_t pc;           // address to fetch
  logic  pred_taken;   // predictor answer for pc
  addr_t pred_target;  // predicted next pc when taken

  // request source, holds fields until accepted or redirected
  modport pc_side (
    output valid,
    output pc,
    output pred_taken,
    output pred_target,
    input  ready
  );

  // request sink
  modport fetch_side (
    input  valid,
    input  pc,
    input  pred_taken,
    input  pred_target,
    output ready
  );

endinterface

// File: source/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor #(
  parameter int BTB_ENTRIES = 16  // power of two
) (
  input  logic             clk,
  input  logic             arst_n_i,
  // lookup, combinational
  input  fetch_pkg::addr_t lookup_pc_i,
  output logic             pred_taken_o,
  output fetch_pkg::addr_t pred_target_o,
  // training from execute
  input  logic             upd_valid_i,
  input  fetch_pkg::addr_t upd_pc_i,
  input  logic             upd_taken_i,
  input  fetch_pkg::addr_t upd_target_i
);

  import fetch_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = XLEN - 2 - IDX_W;  // bits above the index

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // direct mapped btb plus one counter per set
  logic  btb_valid_q  [BTB_ENTRIES];
  tag_t  btb_tag_q    [BTB_ENTRIES];
  addr_t btb_target_q [BTB_ENTRIES];
  ctr_t  ctr_q        [BTB_ENTRIES];

  idx_t lk_idx;
  tag_t lk_tag;
  logic lk_hit;
  idx_t up_idx;
  tag_t up_tag;

  // one saturating step toward the resolved direction
  function automatic ctr_t ctr_step(input ctr_t cur, input logic taken);
    ctr_t nxt;
    nxt = cur;
    if (taken && (cur != 2'b11)) begin
      nxt = cur + 2'd1;
    end else if (!taken && (cur != 2'b00)) begin
      nxt = cur - 2'd1;
    end
    return nxt;
  endfunction

  // word aligned pc, so index starts at bit 2
  assign lk_idx = lookup_pc_i[2 +: IDX_W];
  assign lk_tag = lookup_pc_i[XLEN-1 -: TAG_W];
  assign up_idx = upd_pc_i[2 +: IDX_W];
  assign up_tag = upd_pc_i[XLEN-1 -: TAG_W];

  assign lk_hit        = btb_valid_q[lk_idx] && (btb_tag_q[lk_idx] == lk_tag);
  assign pred_taken_o  = lk_hit && ctr_q[lk_idx][1];  // msb of counter = taken
  assign pred_target_o = btb_target_q[lk_idx];         // only meaningful on taken

  // valid bits and counters, cleared by reset
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_valid_q[i] <= 1'b0;
        ctr_q[i]       <= CTR_RESET;
      end
    end else if (upd_valid_i) begin
      ctr_q[up_idx] <= ctr_step(ctr_q[up_idx], upd_taken_i);
      if (upd_taken_i) begin
        btb_valid_q[up_idx] <= 1'b1;  // allocate on taken only
      end
    end
  end

  // tag and target storage
  always_ff @(posedge clk) begin
    if (upd_valid_i && upd_taken_i) begin
      btb_tag_q[up_idx]    <= up_tag;
      btb_target_q[up_idx] <= upd_target_i;  // overwrite any alias
    end
  end

endmodule

// File: source/pc_stage.sv
`timescale 1ns/100ps

module pc_stage #(
  parameter int               BTB_ENTRIES = 16,
  parameter fetch_pkg::addr_t RESET_PC    = '0
) (
  input  logic             clk,
  input  logic             arst_n_i,
  fetch_req_if.pc_side     req,
  // redirect from execute
  input  logic             redirect_valid_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  // predictor training
  input  logic             upd_valid_i,
  input  fetch_pkg::addr_t upd_pc_i,
  input  logic             upd_taken_i,
  input  fetch_pkg::addr_t upd_target_i
);

  import fetch_pkg::*;

  addr_t pc_q;
  addr_t pc_next;
  logic  valid_q;
  logic  xfer;        // request taken this edge
  logic  bp_taken;
  addr_t bp_target;

  // prediction frozen while a request waits for ready
  logic  lock_q;
  logic  lock_taken_q;
  addr_t lock_target_q;

  branch_predictor #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_bp (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .lookup_pc_i   (pc_q),
    .pred_taken_o  (bp_taken),
    .pred_target_o (bp_target),
    .upd_valid_i   (upd_valid_i),
    .upd_pc_i      (upd_pc_i),
    .upd_taken_i   (upd_taken_i),
    .upd_target_i  (upd_target_i)
  );

  assign req.valid       = valid_q;
  assign req.pc          = pc_q;
  assign req.pred_taken  = lock_q ? lock_taken_q : bp_taken;  // live lookup first cycle
  assign req.pred_target = lock_q ? lock_target_q : bp_target;

  assign xfer = req.valid & req.ready;

  // redirect > advance > hold
  always_comb begin
    pc_next = pc_q;
    if (redirect_valid_i) begin
      pc_next = redirect_pc_i;
    end else if (xfer) begin
      pc_next = req.pred_taken ? req.pred_target : pc_q + INST_BYTES;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
      lock_q  <= 1'b0;
    end else begin
      pc_q    <= pc_next;
      valid_q <= 1'b1;  // always requesting once out of reset
      lock_q  <= valid_q & ~xfer & ~redirect_valid_i;  // stalled, keep answer
    end
  end

  // snapshot of the lookup for a stalled request
  always_ff @(posedge clk) begin
    if (!lock_q) begin
      lock_taken_q  <= bp_taken;
      lock_target_q <= bp_target;
    end
  end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic             clk,
  input  logic             arst_n_i,
  fetch_req_if.fetch_side  req,
  input  logic             redirect_valid_i,
  // read-only apb master
  output fetch_pkg::addr_t paddr_o,
  output logic             psel_o,
  output logic             penable_o,
  input  fetch_pkg::inst_t prdata_i,
  input  logic             pready_i,
  input  logic             pslverr_i,
  // if/id register towards decode
  output logic             inst_valid_o,
  output fetch_pkg::addr_t inst_addr_o,
  output fetch_pkg::inst_t inst_data_o,
  output fetch_pkg::trap_t trap_o,
  output logic             pred_taken_o,
  input  logic             dec_ready_i
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  apb_state_e state_q;
  apb_state_e state_d;

  addr_t paddr_q;  // pc of the item on the bus
  logic  taken_q;  // prediction that travels with it
  logic  drop_q;   // bus item is from a flushed path

  // if/id output register
  logic  out_valid_q;
  addr_t out_addr_q;
  inst_t out_data_q;
  trap_t out_trap_q;
  logic  out_taken_q;

  logic  accept;
  logic  misaligned;
  logic  apb_done;
  logic  load_mis;   // misaligned item straight to output
  logic  load_apb;   // completed read into output
  trap_t mis_trap;
  trap_t apb_trap;

  // at most one on the bus and one in the output register
  assign req.ready  = (state_q == IDLE) & (~out_valid_q | dec_ready_i) & ~redirect_valid_i;
  assign accept     = req.valid & req.ready;
  assign misaligned = |req.pc[1:0];
  assign apb_done   = (state_q == ACCESS) & pready_i;
  assign load_mis   = accept & misaligned;
  assign load_apb   = apb_done & ~drop_q & ~redirect_valid_i;

  always_comb begin
    mis_trap                    = '0;
    mis_trap[TRAP_MISALIGNED]   = misaligned;
    apb_trap                    = '0;
    apb_trap[TRAP_ACCESS_FAULT] = pslverr_i;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept && !misaligned) begin
          state_d = SETUP;
        end
      end
      SETUP: begin
        state_d = ACCESS;  // setup is always one cycle
      end
      ACCESS: begin
        if (pready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      drop_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d == IDLE) begin
        drop_q <= 1'b0;
      end else if (redirect_valid_i) begin
        drop_q <= 1'b1;  // transfer runs to its end and its data is dropped
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      paddr_q <= req.pc;
      taken_q <= req.pred_taken;
    end
  end

  assign paddr_o   = paddr_q;
  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (redirect_valid_i) begin
      out_valid_q <= 1'b0;  // flush wrong path
    end else if (load_mis || load_apb) begin
      out_valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      out_valid_q <= 1'b0;  // drained by decode
    end
  end

  always_ff @(posedge clk) begin
    if (load_mis) begin
      out_addr_q  <= req.pc;
      out_data_q  <= '0;
      out_trap_q  <= mis_trap;
      out_taken_q <= req.pred_taken;
    end else if (load_apb) begin
      out_addr_q  <= paddr_q;
      out_data_q  <= pslverr_i ? '0 : prdata_i;  // no data on error
      out_trap_q  <= apb_trap;
      out_taken_q <= taken_q;
    end
  end

  assign inst_valid_o = out_valid_q;
  assign inst_addr_o  = out_addr_q;
  assign inst_data_o  = out_data_q;
  assign trap_o       = out_trap_q;
  assign pred_taken_o = out_taken_q;

endmodule

// File: source/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
  parameter int               BTB_ENTRIES = 16,  // power of two
  parameter fetch_pkg::addr_t RESET_PC    = '0
) (
  input  logic             clk,
  input  logic             arst_n_i,
  // instruction memory, apb
  output fetch_pkg::addr_t paddr_o,
  output logic             psel_o,
  output logic             penable_o,
  input  fetch_pkg::inst_t prdata_i,
  input  logic             pready_i,
  input  logic             pslverr_i,
  // predictor training from execute
  input  logic             upd_valid_i,
  input  fetch_pkg::addr_t upd_pc_i,
  input  logic             upd_taken_i,
  input  fetch_pkg::addr_t upd_target_i,
  // path change from execute
  input  logic             redirect_valid_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  // to decode
  output logic             inst_valid_o,
  output fetch_pkg::addr_t inst_addr_o,
  output fetch_pkg::inst_t inst_data_o,
  output fetch_pkg::trap_t trap_o,
  output logic             pred_taken_o,
  input  logic             dec_ready_i
);

  fetch_req_if req_if ();  // pc stage -> fetch stage

  pc_stage #(
    .BTB_ENTRIES (BTB_ENTRIES),
    .RESET_PC    (RESET_PC)
  ) u_pc (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .req              (req_if.pc_side),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .upd_valid_i      (upd_valid_i),
    .upd_pc_i         (upd_pc_i),
    .upd_taken_i      (upd_taken_i),
    .upd_target_i     (upd_target_i)
  );

  fetch_stage u_fetch (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .req              (req_if.fetch_side),
    .redirect_valid_i (redirect_valid_i),  // flushes output and bus data
    .paddr_o          (paddr_o),
    .psel_o           (psel_o),
    .penable_o        (penable_o),
    .prdata_i         (prdata_i),
    .pready_i         (pready_i),
    .pslverr_i        (pslverr_i),
    .inst_valid_o     (inst_valid_o),
    .inst_addr_o      (inst_addr_o),
    .inst_data_o      (inst_data_o),
    .trap_o           (trap_o),
    .pred_taken_o     (pred_taken_o),
    .dec_ready_i      (dec_ready_i)
  );

endmodule

// File: sim/fetch_assertions.sv
`timescale 1ns/100ps

module fetch_assertions (
  input logic             clk,
  input logic             arst_n_i,
  input logic             psel_i,
  input logic             penable_i,
  input logic             pready_i,
  input fetch_pkg::addr_t paddr_i,
  input logic             redirect_valid_i,
  input logic             inst_valid_i,
  input fetch_pkg::addr_t inst_addr_i,
  input fetch_pkg::inst_t inst_data_i,
  input fetch_pkg::trap_t trap_i,
  input logic             pred_taken_i,
  input logic             dec_ready_i
);

  // access phase only right after a setup cycle
  a_setup_first: assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(penable_i) |-> $past(psel_i) && !$past(penable_i))
    else $error("penable raised without a setup cycle before it");

  // setup lasts exactly one cycle
  a_setup_len: assert property (@(posedge clk) disable iff (!arst_n_i)
    psel_i && !penable_i |=> psel_i && penable_i)
    else $error("setup cycle not followed by access");

  // address held until the slave completes
  a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    psel_i && !(penable_i && pready_i) |=> psel_i && $stable(paddr_i))
    else $error("paddr changed or psel dropped before pready");

  // if/id register frozen under back-pressure, flush excepted
  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    inst_valid_i && !dec_ready_i && !redirect_valid_i |=>
      inst_valid_i && $stable(inst_addr_i) && $stable(inst_data_i) &&
      $stable(trap_i) && $stable(pred_taken_i))
    else $error("decode outputs changed while stalled");

endmodule

bind fetch_stage fetch_assertions u_fetch_assert (
  .clk              (clk),
  .arst_n_i         (arst_n_i),
  .psel_i           (psel_o),
  .penable_i        (penable_o),
  .pready_i         (pready_i),
  .paddr_i          (paddr_o),
  .redirect_valid_i (redirect_valid_i),
  .inst_valid_i     (inst_valid_o),
  .inst_addr_i      (inst_addr_o),
  .inst_data_i      (inst_data_o),
  .trap_i           (trap_o),
  .pred_taken_i     (pred_taken_o),
  .dec_ready_i      (dec_ready_i)
);

// File: sim/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

  import fetch_pkg::*;

  localparam int    CLK_PERIOD   = 20;
  localparam int    RESET_CYCLES = 16;
  localparam int    BTB_ENTRIES  = 16;
  localparam addr_t RESET_PC     = 32'h0000_0000;
  localparam int    IDX_W        = $clog2(BTB_ENTRIES);
  localparam int    TAG_LSB      = IDX_W + 2;        // tag = pc bits above the index
  localparam inst_t MEM_XOR      = 32'ha5a5_0000;    // memory word = addr ^ this
  localparam addr_t FAULT_BASE   = 32'h0000_f000;    // pslverr from here up
  localparam int    N_ITEMS      = 125;              // 113 waited items plus redirect slack
  localparam int    WATCHDOG_NS  = (RESET_CYCLES + N_ITEMS * 12) * CLK_PERIOD;

  typedef struct packed {
    addr_t addr;
    inst_t data;
    trap_t trap;
    logic  taken;
    addr_t next;   // pc that follows this item
  } exp_item_t;

  logic  clk;
  logic  arst_n_i;
  addr_t paddr_o;
  logic  psel_o;
  logic  penable_o;
  inst_t prdata_i;
  logic  pready_i;
  logic  pslverr_i;
  logic  upd_valid_i;
  addr_t upd_pc_i;
  logic  upd_taken_i;
  addr_t upd_target_i;
  logic  redirect_valid_i;
  addr_t redirect_pc_i;
  logic  inst_valid_o;
  addr_t inst_addr_o;
  inst_t inst_data_o;
  trap_t trap_o;
  logic  pred_taken_o;
  logic  dec_ready_i;

  // predictor mirror, changed only by what goes out on the update port
  logic  m_valid  [BTB_ENTRIES];
  addr_t m_tag    [BTB_ENTRIES];
  addr_t m_target [BTB_ENTRIES];
  ctr_t  m_ctr    [BTB_ENTRIES];

  exp_item_t   exp_q[$];
  addr_t       exp_pc;         // next pc the model will hand out
  logic [31:0] lfsr_q;
  logic        random_mode;    // wait states and decode stalls on
  logic [1:0]  wait_cnt;
  int          value_errors;
  int          other_errors;
  int          delivered;
  int          pred_seen;
  int          mis_seen;
  int          fault_seen;

  fetch_top #(
    .BTB_ENTRIES (BTB_ENTRIES),
    .RESET_PC    (RESET_PC)
  ) dut_i (.*);  // tb signals carry the port names

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic rand_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // reference: what decode must see for a given pc
  function automatic exp_item_t expect_item(input addr_t pc);
    exp_item_t it;
    int        idx;
    idx      = int'(pc[2 +: IDX_W]);
    it.addr  = pc;
    it.taken = m_valid[idx] && (m_tag[idx] == (pc >> TAG_LSB)) && m_ctr[idx][1];
    it.next  = it.taken ? m_target[idx] : pc + INST_BYTES;
    it.trap  = '0;
    it.data  = '0;
    if (pc[1:0] != 2'b00) begin
      it.trap[TRAP_MISALIGNED] = 1'b1;    // never reaches the bus
    end else if (pc >= FAULT_BASE) begin
      it.trap[TRAP_ACCESS_FAULT] = 1'b1;  // slave error, word reads as 0
    end else begin
      it.data = pc ^ MEM_XOR;
    end
    return it;
  endfunction

  task automatic fill_expected();
    exp_item_t it;
    while (exp_q.size() < 4) begin
      it = expect_item(exp_pc);
      exp_q.push_back(it);
      exp_pc = it.next;
    end
  endtask

  // counter saturates toward the outcome, entry written on taken
  task automatic train_model(input addr_t pc, input logic taken, input addr_t target);
    int idx;
    idx = int'(pc[2 +: IDX_W]);
    if (taken) begin
      if (m_ctr[idx] != 2'b11) m_ctr[idx] = m_ctr[idx] + 2'd1;
      m_valid[idx]  = 1'b1;
      m_tag[idx]    = pc >> TAG_LSB;
      m_target[idx] = target;
    end else if (m_ctr[idx] != 2'b00) begin
      m_ctr[idx] = m_ctr[idx] - 2'd1;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_trap(input string name, input trap_t got, input trap_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_counts();
    $display("checked %0d items: %0d value errors, %0d other errors",
             delivered, value_errors, other_errors);
  endtask

  // one cycle redirect pulse, optionally with a predictor update
  task automatic send_redirect(input addr_t pc, input logic upd, input addr_t upd_pc,
                               input logic taken, input addr_t target);
    @(posedge clk);
    #2;
    redirect_valid_i = 1'b1;
    redirect_pc_i    = pc;
    upd_valid_i      = upd;
    upd_pc_i         = upd_pc;
    upd_taken_i      = taken;
    upd_target_i     = target;
    @(posedge clk);
    #2;
    redirect_valid_i = 1'b0;
    upd_valid_i      = 1'b0;
  endtask

  task automatic wait_items(input int n);
    int target;
    target = delivered + n;
    while (delivered < target) @(posedge clk);  // watchdog bounds this
  endtask

  // apb slave and decode ready, driven 2 ns after the edge
  initial begin : apb_memory
    forever begin
      @(posedge clk);
      #2;
      dec_ready_i = 1'b1;
      if (random_mode) dec_ready_i = rand_bit() | rand_bit();  // stall 1 in 4
      pready_i  = 1'b0;
      pslverr_i = 1'b0;
      prdata_i  = '0;
      if (arst_n_i && psel_o && !penable_o) begin  // setup cycle
        if (paddr_o[1:0] != 2'b00) begin
          other_errors++;
          $display("APB read started for misaligned address 0x%h", paddr_o);
        end
        wait_cnt = random_mode ? {rand_bit(), rand_bit()} : 2'd0;
      end else if (arst_n_i && psel_o && penable_o) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt = wait_cnt - 2'd1;
        end else begin
          pready_i  = 1'b1;
          prdata_i  = paddr_o ^ MEM_XOR;  // dut must zero it on error
          pslverr_i = (paddr_o >= FAULT_BASE);
        end
      end
    end
  end

  // sampled mid cycle, where inputs and registered outputs are settled
  always @(negedge clk) begin : compare
    exp_item_t it;
    if (arst_n_i) begin
      if (inst_valid_o && dec_ready_i) begin  // transfer on the coming edge
        fill_expected();
        it = exp_q.pop_front();
        check_addr("inst_addr_o", inst_addr_o, it.addr);
        check_inst("inst_data_o", inst_data_o, it.data);
        check_trap("trap_o", trap_o, it.trap);
        check_bit("pred_taken_o", pred_taken_o, it.taken);
        delivered++;
        if (pred_taken_o) pred_seen++;
        if (trap_o[TRAP_MISALIGNED]) mis_seen++;
        if (trap_o[TRAP_ACCESS_FAULT]) fault_seen++;
      end
      if (upd_valid_i) train_model(upd_pc_i, upd_taken_i, upd_target_i);
      if (redirect_valid_i) begin
        exp_q.delete();  // old path gone
        exp_pc = redirect_pc_i;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, instructions stopped arriving", WATCHDOG_NS);
    report_counts();
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    int seen_before;
    arst_n_i         = 1'b0;
    prdata_i         = '0;
    pready_i         = 1'b0;
    pslverr_i        = 1'b0;
    upd_valid_i      = 1'b0;
    upd_pc_i         = '0;
    upd_taken_i      = 1'b0;
    upd_target_i     = '0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    dec_ready_i      = 1'b1;
    lfsr_q           = 32'h6f33;
    random_mode      = 1'b0;
    wait_cnt         = 2'd0;
    value_errors     = 0;
    other_errors     = 0;
    delivered        = 0;
    pred_seen        = 0;
    mis_seen         = 0;
    fault_seen       = 0;
    exp_pc           = RESET_PC;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_valid[i]  = 1'b0;
      m_tag[i]    = '0;
      m_target[i] = '0;
      m_ctr[i]    = CTR_RESET;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n_i = 1'b1;

    wait_items(20);             // plain sequential stream
    @(negedge clk);
    random_mode = 1'b1;
    wait_items(40);             // same stream under waits and stalls

    send_redirect(32'h0000_0200, 1'b0, '0, 1'b0, '0);
    wait_items(10);
    send_redirect(32'h0000_0400, 1'b0, '0, 1'b0, '0);
    wait_items(10);

    // 0x308 becomes a taken branch back to 0x300, counter ends strong taken
    send_redirect(32'h0000_0300, 1'b1, 32'h0000_0308, 1'b1, 32'h0000_0300);
    send_redirect(32'h0000_0300, 1'b1, 32'h0000_0308, 1'b1, 32'h0000_0300);
    seen_before = pred_seen;
    wait_items(15);
    if (pred_seen == seen_before) begin
      other_errors++;
      $display("trained branch at 0x308 never came out predicted taken");
    end
    // two not taken outcomes, back to weak not taken
    send_redirect(32'h0000_0300, 1'b1, 32'h0000_0308, 1'b0, '0);
    send_redirect(32'h0000_0300, 1'b1, 32'h0000_0308, 1'b0, '0);
    seen_before = pred_seen;
    wait_items(10);
    if (pred_seen != seen_before) begin
      other_errors++;
      $display("branch at 0x308 still predicted taken after not taken training");
    end

    seen_before = mis_seen;
    send_redirect(32'h0000_0102, 1'b0, '0, 1'b0, '0);
    wait_items(4);
    if (mis_seen == seen_before) begin
      other_errors++;
      $display("misaligned redirect delivered no misaligned trap");
    end
    seen_before = fault_seen;
    send_redirect(FAULT_BASE, 1'b0, '0, 1'b0, '0);
    wait_items(4);
    if (fault_seen == seen_before) begin
      other_errors++;
      $display("redirect into the error region delivered no access fault");
    end

    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: flist.f
source/fetch_pkg.sv
source/fetch_req_if.sv
source/branch_predictor.sv
source/pc_stage.sv
source/fetch_stage.sv
source/fetch_top.sv
sim/fetch_assertions.sv
sim/fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
